//--- hw/alu.sv
`timescale 1ns/100ps

module alu (
    input  netcore_pkg::instr_s                instr_i,
    input  logic [netcore_pkg::DATA_W-1:0]      rd_val_i,
    input  logic [netcore_pkg::DATA_W-1:0]      rs_val_i,
    input  logic [netcore_pkg::IMEM_ADDR_W-1:0] pc_i,
    output logic [netcore_pkg::DATA_W-1:0]      result_o,
    output logic                               branch_taken_o,
    output logic [netcore_pkg::IMEM_ADDR_W-1:0] branch_target_o
);
    import netcore_pkg::*;

    // Result path
    always_comb
    begin
        case (instr_i.opcode)
            OP_ADDU: result_o = rd_val_i + rs_val_i;
            OP_SUBU: result_o = rd_val_i - rs_val_i;
            OP_AND: result_o = rd_val_i & rs_val_i;
            OP_OR: result_o = rd_val_i | rs_val_i;
            // BAR publishes rs, same path as MOV
            OP_MOV, OP_BAR: result_o = rs_val_i;
            default: result_o = '0;
        endcase
    end

    // Branch condition tests rd against zero
    always_comb
    begin
        case (instr_i.opcode)
            OP_BEQZ: branch_taken_o = (rd_val_i == '0);
            OP_BNEQZ: branch_taken_o = (rd_val_i != '0);
            default: branch_taken_o = 1'b0;
        endcase
    end

    // Sign-extended offset from the branch's own PC
    assign branch_target_o = pc_i
        + {{(IMEM_ADDR_W-REG_ADDR_W){instr_i.rs_imm[REG_ADDR_W-1]}}, instr_i.rs_imm};

endmodule

//--- hw/core_ctrl.sv
`timescale 1ns/100ps

module core_ctrl #(
    parameter logic [netcore_pkg::NET_ID_W-1:0] NET_ID = 10'd1
) (
    input  logic                          clk,
    input  logic                          n_reset,
    input  netcore_pkg::net_packet_s      net_packet_i,
    input  netcore_pkg::instr_s           instr_2_i,
    input  logic [netcore_pkg::DATA_W-1:0] alu_result_i,
    input  logic                          rf_write_2_i,
    output logic                          net_imem_we_o,
    output logic                          net_reg_we_o,
    output logic                          pc_load_o,
    output logic                          stall_o,
    output netcore_pkg::state_e           state_o,
    output logic [netcore_pkg::MASK_W-1:0] barrier_o,
    output logic                          exception_o
);
    import netcore_pkg::*;

    logic              id_match;
    logic              net_pc_cmd;
    logic              net_bar_cmd;
    logic              commit;
    state_e            state_n;
    logic [MASK_W-1:0] mask_r;
    logic [MASK_W-1:0] barrier_r;

    // Command decode, NET_NULL packets are ignored
    assign id_match      = (net_packet_i.id == NET_ID) && (net_packet_i.op != NET_NULL);
    assign net_imem_we_o = id_match && (net_packet_i.op == NET_INSTR);
    assign net_reg_we_o  = id_match && (net_packet_i.op == NET_REG);
    assign net_pc_cmd    = id_match && (net_packet_i.op == NET_PC);
    assign net_bar_cmd   = id_match && (net_packet_i.op == NET_BAR);
    assign pc_load_o     = net_pc_cmd && (state_o == ST_IDLE);

    // Hold the pipe outside RUN, on imem port conflict, or on a register port conflict
    assign stall_o = (state_o != ST_RUN)
                  || net_imem_we_o
                  || (net_reg_we_o && rf_write_2_i);

    // Stage 2 retires on any unstalled edge
    assign commit = !stall_o;

    always_comb
    begin
        state_n = state_o;
        if (exception_o)
            state_n = ST_ERR;
        else if (pc_load_o)
            state_n = ST_RUN;
        else if ((state_o == ST_RUN) && commit && (instr_2_i.opcode == OP_WAIT))
            state_n = ST_IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_o     <= ST_IDLE;
            exception_o <= 1'b0;
            mask_r      <= '0;
            barrier_r   <= '0;
        end
        else
        begin
            state_o <= state_n;
            // Sticky, a start while busy is an error
            if (net_pc_cmd && (state_o != ST_IDLE))
                exception_o <= 1'b1;
            // Mask frozen once in error
            if (net_bar_cmd && (state_o != ST_ERR))
                mask_r <= net_packet_i.data[MASK_W-1:0];
            // Start value comes with the PC write, later ones from BAR
            if (pc_load_o)
                barrier_r <= net_packet_i.data[MASK_W-1:0];
            else if (commit && (instr_2_i.opcode == OP_BAR))
                barrier_r <= alu_result_i[MASK_W-1:0];
        end
    end

    assign barrier_o = mask_r & barrier_r;

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                               clk,
    input  logic                               n_reset,
    input  logic                               stall_i,
    input  logic                               branch_taken_i,
    input  logic                               net_reg_we_i,
    input  netcore_pkg::net_packet_s           net_packet_i,
    input  netcore_pkg::instr_s                instr_1_i,
    input  logic [netcore_pkg::IMEM_ADDR_W-1:0] pc_1_i,
    input  logic [netcore_pkg::DATA_W-1:0]      alu_result_i,
    output netcore_pkg::instr_s                instr_2_o,
    output logic [netcore_pkg::IMEM_ADDR_W-1:0] pc_2_o,
    output logic [netcore_pkg::DATA_W-1:0]      rs_val_2_o,
    output logic [netcore_pkg::DATA_W-1:0]      rd_val_2_o,
    output logic                               rf_write_2_o
);
    import netcore_pkg::*;

    logic [REG_ADDR_W-1:0] w_addr;
    logic [DATA_W-1:0]     w_data;
    logic                  rf_we;
    logic [DATA_W-1:0]     rs_val;
    logic [DATA_W-1:0]     rd_val;
    logic                  writes_rd_1;
    logic                  bypass_rs;
    logic                  bypass_rd;

    // Network write takes the port, stall holds off the stage-2 write
    assign w_addr = net_reg_we_i ? net_packet_i.addr[REG_ADDR_W-1:0] : instr_2_o.rd;
    assign w_data = net_reg_we_i ? net_packet_i.data : alu_result_i;
    assign rf_we  = net_reg_we_i || (rf_write_2_o && !stall_i);

    reg_file rf (
        .clk       (clk),
        .rs_addr_i (instr_1_i.rs_imm),
        .rd_addr_i (instr_1_i.rd),
        .w_addr_i  (w_addr),
        .we_i      (rf_we),
        .w_data_i  (w_data),
        .rs_val_o  (rs_val),
        .rd_val_o  (rd_val)
    );

    // Only ALU ops and MOV produce a register result
    always_comb
    begin
        case (instr_1_i.opcode)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_MOV: writes_rd_1 = 1'b1;
            default: writes_rd_1 = 1'b0;
        endcase
    end

    // Forward the value being written this cycle, never into r0
    assign bypass_rs = rf_we && (w_addr != '0) && (w_addr == instr_1_i.rs_imm);
    assign bypass_rd = rf_we && (w_addr != '0) && (w_addr == instr_1_i.rd);

    always_ff @(posedge clk)
    begin
        if (!n_reset || (branch_taken_i && !stall_i))
        begin
            instr_2_o    <= '0;
            pc_2_o       <= '0;
            rs_val_2_o   <= '0;
            rd_val_2_o   <= '0;
            rf_write_2_o <= 1'b0;
        end
        else if (!stall_i)
        begin
            instr_2_o    <= instr_1_i;
            pc_2_o       <= pc_1_i;
            rs_val_2_o   <= bypass_rs ? w_data : rs_val;
            rd_val_2_o   <= bypass_rd ? w_data : rd_val;
            rf_write_2_o <= writes_rd_1;
        end
    end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                               clk,
    input  logic                               n_reset,
    input  logic                               stall_i,
    input  logic                               pc_load_i,
    input  logic                               net_imem_we_i,
    input  netcore_pkg::net_packet_s           net_packet_i,
    input  logic                               branch_taken_i,
    input  logic [netcore_pkg::IMEM_ADDR_W-1:0] branch_target_i,
    input  netcore_pkg::instr_s                ex_instr_i,
    output netcore_pkg::instr_s                instr_1_o,
    output logic [netcore_pkg::IMEM_ADDR_W-1:0] pc_1_o,
    output logic [netcore_pkg::IMEM_ADDR_W-1:0] pc_o
);
    import netcore_pkg::*;

    logic [IMEM_ADDR_W-1:0] pc_r;
    logic [IMEM_ADDR_W-1:0] pc_n;
    logic [IMEM_ADDR_W-1:0] imem_addr;
    instr_s                 imem_rdata;
    instr_s                 net_instr;
    logic                   insert_nop;

    // Next PC, network load wins over everything
    always_comb
    begin
        if (pc_load_i)
            pc_n = net_packet_i.addr;
        else if (branch_taken_i)
            pc_n = branch_target_i;
        else if (!stall_i)
            pc_n = pc_r + 1'b1;
        else
            pc_n = pc_r;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            pc_r <= '0;
        else
            pc_r <= pc_n;
    end

    // Memory looks one cycle ahead using next PC
    // Network writes borrow the port
    assign imem_addr = net_imem_we_i ? net_packet_i.addr : pc_n;
    assign net_instr = instr_s'(net_packet_i.data[$bits(instr_s)-1:0]);

    instr_mem imem (
        .clk     (clk),
        .addr_i  (imem_addr),
        .we_i    (net_imem_we_i),
        .wdata_i (net_instr),
        .rdata_o (imem_rdata)
    );

    // Bubble after a taken branch, and stop fetching once WAIT is in flight
    assign insert_nop = branch_taken_i
                     || (instr_1_o.opcode == OP_WAIT)
                     || (ex_instr_i.opcode == OP_WAIT);

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            instr_1_o <= '0;
            pc_1_o    <= '0;
        end
        else if (!stall_i)
        begin
            instr_1_o <= insert_nop ? instr_s'('0) : imem_rdata;
            pc_1_o    <= pc_r;
        end
    end

    assign pc_o = pc_r;

endmodule

//--- hw/instr_mem.sv
`timescale 1ns/100ps

module instr_mem (
    input  logic                               clk,
    input  logic [netcore_pkg::IMEM_ADDR_W-1:0] addr_i,
    input  logic                               we_i,
    input  netcore_pkg::instr_s                wdata_i,
    output netcore_pkg::instr_s                rdata_o
);
    import netcore_pkg::*;

    // One word per instruction address
    instr_s mem [2**IMEM_ADDR_W];

    // Registered read, write shares the same address
    always_ff @(posedge clk)
    begin
        if (we_i)
        begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

//--- hw/netcore_pkg.sv
package netcore_pkg;

    // Widths shared across the core
    localparam int IMEM_ADDR_W = 10;
    localparam int REG_ADDR_W  = 5;
    localparam int DATA_W      = 32;
    localparam int MASK_W      = 8;
    localparam int NET_ID_W    = 10;

    // Instruction opcodes, NOP must stay zero so a cleared register is a bubble
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_MOV,
        OP_BEQZ,
        OP_BNEQZ,
        OP_BAR,
        OP_WAIT
    } opcode_e;

    // 16-bit instruction word
    // Branch offset in rs_imm is signed and relative to the branch's own PC
    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs_imm;
    } instr_s;

    // Network command types
    typedef enum logic [2:0] {
        NET_NULL = 3'd0,
        NET_INSTR,
        NET_REG,
        NET_PC,
        NET_BAR
    } net_op_e;

    // One packet per cycle on the network port
    typedef struct packed {
        logic [NET_ID_W-1:0]    id;
        net_op_e                op;
        logic [IMEM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
    } net_packet_s;

    // Run state of the core
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN,
        ST_ERR
    } state_e;

    typedef struct packed {
        logic [IMEM_ADDR_W-1:0] pc;
        state_e                 state;
    } debug_s;

endpackage

//--- hw/netcore_top.sv
`timescale 1ns/100ps

module netcore_top #(
    parameter logic [netcore_pkg::NET_ID_W-1:0] NET_ID = 10'd1
) (
    input  logic                          clk,
    input  logic                          n_reset,
    input  netcore_pkg::net_packet_s      net_packet_i,
    output logic [netcore_pkg::MASK_W-1:0] barrier_o,
    output logic                          exception_o,
    output netcore_pkg::debug_s           debug_o
);
    import netcore_pkg::*;

    // Controller strobes
    logic   net_imem_we;
    logic   net_reg_we;
    logic   pc_load;
    logic   stall;
    state_e state;

    // Stage 1
    instr_s                 instr_1;
    logic [IMEM_ADDR_W-1:0] pc_1;
    logic [IMEM_ADDR_W-1:0] pc;

    // Stage 2
    instr_s                 instr_2;
    logic [IMEM_ADDR_W-1:0] pc_2;
    logic [DATA_W-1:0]      rs_val_2;
    logic [DATA_W-1:0]      rd_val_2;
    logic                   rf_write_2;

    // ALU outputs
    logic [DATA_W-1:0]      alu_result;
    logic                   branch_taken;
    logic [IMEM_ADDR_W-1:0] branch_target;

    fetch_stage fetch (
        .clk             (clk),
        .n_reset         (n_reset),
        .stall_i         (stall),
        .pc_load_i       (pc_load),
        .net_imem_we_i   (net_imem_we),
        .net_packet_i    (net_packet_i),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .ex_instr_i      (instr_2),
        .instr_1_o       (instr_1),
        .pc_1_o          (pc_1),
        .pc_o            (pc)
    );

    decode_stage decode (
        .clk            (clk),
        .n_reset        (n_reset),
        .stall_i        (stall),
        .branch_taken_i (branch_taken),
        .net_reg_we_i   (net_reg_we),
        .net_packet_i   (net_packet_i),
        .instr_1_i      (instr_1),
        .pc_1_i         (pc_1),
        .alu_result_i   (alu_result),
        .instr_2_o      (instr_2),
        .pc_2_o         (pc_2),
        .rs_val_2_o     (rs_val_2),
        .rd_val_2_o     (rd_val_2),
        .rf_write_2_o   (rf_write_2)
    );

    alu ex_alu (
        .instr_i         (instr_2),
        .rd_val_i        (rd_val_2),
        .rs_val_i        (rs_val_2),
        .pc_i            (pc_2),
        .result_o        (alu_result),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    core_ctrl #(
        .NET_ID (NET_ID)
    ) ctrl (
        .clk           (clk),
        .n_reset       (n_reset),
        .net_packet_i  (net_packet_i),
        .instr_2_i     (instr_2),
        .alu_result_i  (alu_result),
        .rf_write_2_i  (rf_write_2),
        .net_imem_we_o (net_imem_we),
        .net_reg_we_o  (net_reg_we),
        .pc_load_o     (pc_load),
        .stall_o       (stall),
        .state_o       (state),
        .barrier_o     (barrier_o),
        .exception_o   (exception_o)
    );

    // Debug view, fetch PC and run state
    assign debug_o = '{pc: pc, state: state};

endmodule

//--- hw/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                              clk,
    input  logic [netcore_pkg::REG_ADDR_W-1:0] rs_addr_i,
    input  logic [netcore_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [netcore_pkg::REG_ADDR_W-1:0] w_addr_i,
    input  logic                              we_i,
    input  logic [netcore_pkg::DATA_W-1:0]     w_data_i,
    output logic [netcore_pkg::DATA_W-1:0]     rs_val_o,
    output logic [netcore_pkg::DATA_W-1:0]     rd_val_o
);
    import netcore_pkg::*;

    logic [DATA_W-1:0] regs [2**REG_ADDR_W];

    // Single write port, clocked
    always_ff @(posedge clk)
    begin
        if (we_i)
        begin
            regs[w_addr_i] <= w_data_i;
        end
    end

    // Asynchronous reads
    // Register zero is hardwired to zero whatever was written there
    assign rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule

//--- netcore.f
hw/netcore_pkg.sv
hw/instr_mem.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/alu.sv
hw/core_ctrl.sv
hw/netcore_top.sv
tests/netcore_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the netcore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f netcore.f \
    --top-module netcore_tb \
    -o Vnetcore_tb

./obj_dir/Vnetcore_tb

//--- tests/netcore_tb.sv
`timescale 1ns/100ps

module netcore_tb;
    import netcore_pkg::*;

    localparam logic [NET_ID_W-1:0] CORE_ID = 10'd5;
    localparam int N_ROWS     = 4;
    localparam int PROG_LEN   = 8;
    localparam int CLK_PERIOD = 100;

    // One test case
    // Program word 0 is the entry point
    typedef struct packed {
        instr_s [PROG_LEN-1:0]  prog;
        logic [7:1][DATA_W-1:0] regs;
        logic [MASK_W-1:0]      mask;
        logic [MASK_W-1:0]      start;
        logic [MASK_W-1:0]      exp_val;
    } test_row_s;

    logic              clk;
    logic              n_reset;
    net_packet_s       pkt;
    logic [MASK_W-1:0] barrier;
    logic              exception;
    debug_s            debug;
    test_row_s         rows [N_ROWS];
    logic [31:0]       lcg_state;

    netcore_top #(
        .NET_ID (CORE_ID)
    ) DUT (
        .clk          (clk),
        .n_reset      (n_reset),
        .net_packet_i (pkt),
        .barrier_o    (barrier),
        .exception_o  (exception),
        .debug_o      (debug)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // Bound on the whole run
    initial
    begin
        #(N_ROWS * 2000 * CLK_PERIOD);
        $display("Timeout: the core never finished the test sequence");
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic instr_s encode(opcode_e op, int rd, int rs);
        instr_s ins;
        ins.opcode = op;
        ins.rd     = rd[REG_ADDR_W-1:0];
        ins.rs_imm = rs[REG_ADDR_W-1:0];
        return ins;
    endfunction

    // Sequential ISA interpreter
    // Returns the last published barrier value
    function automatic logic [MASK_W-1:0] model_value(test_row_s row);
        logic [DATA_W-1:0] r [32];
        logic [MASK_W-1:0] bar;
        instr_s            ins;
        int                pc;
        int                steps;
        int                i;
        for (i = 0; i < 32; i++)
            r[i] = '0;
        for (i = 1; i < 8; i++)
            r[i] = row.regs[i];
        bar   = row.start;
        pc    = 0;
        steps = 0;
        while (pc >= 0 && pc < PROG_LEN && steps < 1000)
        begin
            ins = row.prog[pc];
            steps++;
            case (ins.opcode)
                OP_ADDU: r[ins.rd] = r[ins.rd] + r[ins.rs_imm];
                OP_SUBU: r[ins.rd] = r[ins.rd] - r[ins.rs_imm];
                OP_AND: r[ins.rd] = r[ins.rd] & r[ins.rs_imm];
                OP_OR: r[ins.rd] = r[ins.rd] | r[ins.rs_imm];
                OP_MOV: r[ins.rd] = r[ins.rs_imm];
                OP_BAR: bar = r[ins.rs_imm][MASK_W-1:0];
                OP_WAIT: return bar;
                default: ;
            endcase
            // Branch offsets count from the branch itself
            if ((ins.opcode == OP_BEQZ && r[ins.rd] == '0)
                || (ins.opcode == OP_BNEQZ && r[ins.rd] != '0))
                pc = pc + int'($signed(ins.rs_imm));
            else
                pc = pc + 1;
            // r0 reads as zero whatever was written
            r[0] = '0;
        end
        return bar;
    endfunction

    task automatic report_error(string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "Stopped at the first error");
    endtask

    // Entered 10 ns after an edge
    // Returns 10 ns after the edge that samples the packet
    task automatic send_cmd(net_op_e op, int addr, logic [DATA_W-1:0] data);
        pkt.id   = CORE_ID;
        pkt.op   = op;
        pkt.addr = addr[IMEM_ADDR_W-1:0];
        pkt.data = data;
        @(posedge clk);
        #10;
        pkt = '0;
    endtask

    task automatic check_barrier(int row, logic [MASK_W-1:0] exp, string what);
        assert (barrier == exp)
        else report_error($sformatf("row %0d %s, barrier_o %h expected %h",
                                    row, what, barrier, exp));
    endtask

    task automatic check_state(state_e exp, string what);
        assert (debug.state == exp)
        else report_error($sformatf("%s, state %0d expected %0d", what, debug.state, exp));
    endtask

    // Poll once per cycle until the core drops back to IDLE
    task automatic wait_idle();
        do
        begin
            @(posedge clk);
            #10;
        end
        while (debug.state != ST_IDLE);
    endtask

    task automatic build_rows();
        logic [31:0] rnd;
        int          r;
        int          i;
        for (r = 0; r < N_ROWS; r++)
        begin
            // Unused words stop the core
            for (i = 0; i < PROG_LEN; i++)
                rows[r].prog[i] = encode(OP_WAIT, 0, 0);
            for (i = 1; i <= 3; i++)
                rows[r].regs[i] = lcg_next();
            // r4 counts loops and r5 is the decrement
            rnd = lcg_next();
            rows[r].regs[4] = {28'b0, rnd[27:24]} + 32'd2;
            rows[r].regs[5] = 32'd1;
            rows[r].regs[6] = '0;
            rows[r].regs[7] = '0;
        end
        // Back-to-back ALU dependencies
        rows[0].prog[0] = encode(OP_ADDU, 1, 2);
        rows[0].prog[1] = encode(OP_SUBU, 1, 3);
        rows[0].prog[2] = encode(OP_AND, 2, 1);
        rows[0].prog[3] = encode(OP_OR, 2, 3);
        rows[0].prog[4] = encode(OP_MOV, 6, 2);
        rows[0].prog[5] = encode(OP_BAR, 0, 6);
        // Same chain on one register, both operands bypassed
        rows[1].prog[0] = encode(OP_MOV, 6, 1);
        rows[1].prog[1] = encode(OP_ADDU, 6, 6);
        rows[1].prog[2] = encode(OP_SUBU, 6, 2);
        rows[1].prog[3] = encode(OP_OR, 6, 4);
        rows[1].prog[4] = encode(OP_AND, 6, 3);
        rows[1].prog[5] = encode(OP_BAR, 0, 6);
        // Countdown closed by BNEQZ
        // The ADDU after it runs once
        rows[2].prog[0] = encode(OP_MOV, 6, 0);
        rows[2].prog[1] = encode(OP_ADDU, 6, 1);
        rows[2].prog[2] = encode(OP_SUBU, 4, 5);
        rows[2].prog[3] = encode(OP_BNEQZ, 4, -2);
        rows[2].prog[4] = encode(OP_ADDU, 6, 2);
        rows[2].prog[5] = encode(OP_BAR, 0, 6);
        // BEQZ exit plus BEQZ on r0 as a jump back
        rows[3].prog[0] = encode(OP_ADDU, 7, 2);
        rows[3].prog[1] = encode(OP_SUBU, 4, 5);
        rows[3].prog[2] = encode(OP_BEQZ, 4, 3);
        rows[3].prog[3] = encode(OP_OR, 7, 1);
        rows[3].prog[4] = encode(OP_BEQZ, 0, -4);
        rows[3].prog[5] = encode(OP_BAR, 0, 7);
        rows[0].mask  = 8'hff;
        rows[0].start = 8'h81;
        rows[1].mask  = 8'h5a;
        rows[1].start = 8'h7e;
        rows[2].mask  = 8'hf0;
        rows[2].start = 8'h11;
        rows[3].mask  = 8'h3c;
        rows[3].start = 8'hc3;
        for (r = 0; r < N_ROWS; r++)
            rows[r].exp_val = model_value(rows[r]);
    endtask

    task automatic run_row(int r);
        int base;
        int i;
        // Each row gets its own 16-word slot in instruction memory
        base = r * 16;
        for (i = 0; i < PROG_LEN; i++)
            send_cmd(NET_INSTR, base + i, {16'b0, rows[r].prog[i]});
        for (i = 1; i < 8; i++)
            send_cmd(NET_REG, i, rows[r].regs[i]);
        send_cmd(NET_BAR, 0, {24'b0, rows[r].mask});
        send_cmd(NET_PC, base, {24'b0, rows[r].start});
        check_state(ST_RUN, "after start");
        assert (debug.pc == base[IMEM_ADDR_W-1:0])
        else report_error($sformatf("row %0d after start, debug_o.pc %0d expected %0d",
                                    r, debug.pc, base));
        check_barrier(r, rows[r].mask & rows[r].start, "after start");
        wait_idle();
        check_barrier(r, rows[r].mask & rows[r].exp_val, "after program");
        // New mask shows on the very next edge
        send_cmd(NET_BAR, 0, {24'b0, ~rows[r].mask});
        check_barrier(r, ~rows[r].mask & rows[r].exp_val, "after mask change");
    endtask

    task automatic run_exception();
        logic [MASK_W-1:0] start_val;
        logic [MASK_W-1:0] exp_bar;
        int                base;
        base      = N_ROWS * 16;
        start_val = 8'ha5;
        // Tight countdown from 64K keeps the core in RUN
        send_cmd(NET_INSTR, base, {16'b0, encode(OP_SUBU, 4, 5)});
        send_cmd(NET_INSTR, base + 1, {16'b0, encode(OP_BNEQZ, 4, -1)});
        send_cmd(NET_INSTR, base + 2, {16'b0, encode(OP_WAIT, 0, 0)});
        send_cmd(NET_REG, 4, 32'h0001_0000);
        send_cmd(NET_REG, 5, 32'd1);
        send_cmd(NET_PC, base, {24'b0, start_val});
        repeat (20) @(posedge clk);
        #10;
        check_state(ST_RUN, "long loop before second start");
        send_cmd(NET_PC, base, 32'h0);
        assert (exception == 1'b1)
        else report_error("exception_o still low after a start while running");
        check_state(ST_RUN, "edge of second start");
        @(posedge clk);
        #10;
        check_state(ST_ERR, "edge after exception");
        // Mask left by the last row, value from this start
        // The loop publishes nothing
        exp_bar = ~rows[N_ROWS-1].mask & start_val;
        check_barrier(N_ROWS, exp_bar, "entering error state");
        send_cmd(NET_BAR, 0, {24'b0, rows[N_ROWS-1].mask});
        check_barrier(N_ROWS, exp_bar, "mask write in error state");
        assert (exception == 1'b1)
        else report_error("exception_o dropped in error state");
    endtask

    initial
    begin
        clk       = 1'b0;
        n_reset   = 1'b0;
        pkt       = '0;
        lcg_state = 32'd50865;
        build_rows();
        repeat (10) @(posedge clk);
        #10;
        n_reset = 1'b1;
        assert (barrier == '0 && exception == 1'b0)
        else report_error("barrier_o or exception_o not cleared by reset");
        assert (debug.pc == '0)
        else report_error("debug_o.pc not cleared by reset");
        check_state(ST_IDLE, "after reset");
        for (int r = 0; r < N_ROWS; r++)
            run_row(r);
        run_exception();
        $display("Done: no errors");
        $finish;
    end

endmodule
